//--- cvita_port_bridge.f
design/cvita_pkg.sv
design/sink_demux.sv
design/sample_framer.sv
design/source_arbiter.sv
design/seqnum_rewriter.sv
design/cvita_port_bridge.sv
dv/tb_cvita_port_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build the port bridge testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f cvita_port_bridge.f \
  --top-module tb_cvita_port_bridge \
  --Mdir obj_dir -o tb_cvita_port_bridge

./obj_dir/tb_cvita_port_bridge

//--- dv/tb_cvita_port_bridge.sv
//////////////////////////////////////////////////
// CVITA port bridge testbench
// Drives sink packets, sample bursts and raw packets
// through the bridge and checks every output word
// against queues of expected words
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cvita_port_bridge;
  import cvita_pkg::*;

  localparam int          MTU_LOG2    = 3;
  localparam int          MAX_WORDS   = 2 ** MTU_LOG2;
  localparam logic [15:0] SRC_SID     = 16'h0a11;
  localparam logic [15:0] DST_SID     = 16'h0b22;
  // Raw source packets carry their own source SID so they can be told apart
  localparam logic [15:0] RAW_SID     = 16'hc0de;
  localparam int          N_SINK      = 6;
  localparam int          N_RAW       = 10;
  localparam int          N_SAMP      = 11;
  localparam int          MODE_RAW    = 0;
  localparam int          MODE_SAMPLE = 1;
  localparam int          MODE_BOTH   = 2;
  localparam int SENT_WORDS = 3 * N_SINK * (MAX_WORDS + 1)
                            + 2 * (N_RAW * (MAX_WORDS + 1) + N_SAMP * (3 * MAX_WORDS + 3));

  logic                 ce_clk;
  logic                 i_rst;
  logic                 i_clear;
  logic [HDR_SID_W-1:0] i_src_sid;
  logic [HDR_SID_W-1:0] i_dst_sid;
  logic [CVITA_W-1:0]   i_sink_data;
  logic                 i_sink_last;
  logic                 i_sink_valid;
  logic                 o_sink_ready;
  logic [CVITA_W-1:0]   o_cvita_data;
  logic                 o_cvita_last;
  logic                 o_cvita_valid;
  logic                 i_cvita_ready;
  logic [CVITA_W-1:0]   o_samp_data;
  logic                 o_samp_last;
  logic                 o_samp_valid;
  logic                 i_samp_ready;
  logic [CVITA_W-1:0]   i_samp_data;
  logic                 i_samp_last;
  logic                 i_samp_valid;
  logic                 o_samp_ready_in;
  logic [CVITA_W-1:0]   i_cvita_in_data;
  logic                 i_cvita_in_last;
  logic                 i_cvita_in_valid;
  logic                 o_cvita_in_ready;
  logic [CVITA_W-1:0]   o_src_data;
  logic                 o_src_last;
  logic                 o_src_valid;
  logic                 i_src_ready;

  // Queue entries are {last, data}
  logic [CVITA_W:0]     cv_q[$];
  logic [CVITA_W:0]     sp_q[$];
  logic [CVITA_W:0]     raw_q[$];
  logic [CVITA_W:0]     fr_q[$];
  logic [CVITA_W:0]     samp_stim[$];
  logic [CVITA_W:0]     raw_stim[$];
  logic [CVITA_W:0]     cv_exp;
  logic [CVITA_W:0]     sp_exp;
  logic [CVITA_W:0]     src_exp;
  logic [HDR_SEQ_W-1:0] exp_seq;
  logic                 src_in_pkt;
  logic                 src_from_raw;
  logic [31:0]          lfsr = 32'h7909;

  cvita_port_bridge #(
    .MTU_LOG2       (MTU_LOG2),
    .REWRITE_SEQNUM (1)
  ) dut_i (.*);

  initial begin
    ce_clk = 1'b0;
    forever #5 ce_clk = ~ce_clk;
  end

  initial begin
    repeat (40 * SENT_WORDS + 1000) @(posedge ce_clk);
    stop_on_failure("Timeout: the DUT did not finish moving the test traffic");
  end

  //////////////////////////////////////////////////
  // Random numbers and failure reporting
  //////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic rand_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      val = {val[62:0], rand_bit()};
    end
    return val;
  endfunction

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] got_v);
    stop_on_failure($sformatf("ERROR %s expected %h got %h", name, exp_v, got_v));
  endtask

  //////////////////////////////////////////////////
  // Output checkers
  //////////////////////////////////////////////////

  always @(posedge ce_clk) begin
    if (!i_rst && o_cvita_valid) begin
      assert (cv_q.size() > 0)
        else stop_on_failure("Raw-packet output went valid with no word expected");
      if (i_cvita_ready && cv_q.size() > 0) begin
        cv_exp = cv_q.pop_front();
        assert (o_cvita_data == cv_exp[63:0])
          else report_mismatch("o_cvita_data", cv_exp[63:0], o_cvita_data);
        assert (o_cvita_last == cv_exp[64])
          else report_mismatch("o_cvita_last", 64'(cv_exp[64]), 64'(o_cvita_last));
      end
    end
  end

  always @(posedge ce_clk) begin
    if (!i_rst && o_samp_valid) begin
      assert (sp_q.size() > 0)
        else stop_on_failure("Sample output went valid with no word expected");
      if (i_samp_ready && sp_q.size() > 0) begin
        sp_exp = sp_q.pop_front();
        assert (o_samp_data == sp_exp[63:0])
          else report_mismatch("o_samp_data", sp_exp[63:0], o_samp_data);
        assert (o_samp_last == sp_exp[64])
          else report_mismatch("o_samp_last", 64'(sp_exp[64]), 64'(o_samp_last));
      end
    end
  end

  // Header words get the running sequence count in place of their own field
  always @(posedge ce_clk) begin
    if (i_rst || i_clear) begin
      exp_seq    = '0;
      src_in_pkt = 1'b0;
    end else if (o_src_valid) begin
      assert (raw_q.size() + fr_q.size() > 0)
        else stop_on_failure("Source output went valid with no packet expected");
      if (i_src_ready) begin
        if (!src_in_pkt) begin
          src_from_raw = (o_src_data[HDR_SRC_LSB +: HDR_SID_W] == RAW_SID);
        end
        if (src_from_raw) begin
          assert (raw_q.size() > 0)
            else stop_on_failure("Source output carried a raw word that was never sent");
          if (raw_q.size() > 0) src_exp = raw_q.pop_front();
        end else begin
          assert (fr_q.size() > 0)
            else stop_on_failure("Source output carried a framed word that was never sent");
          if (fr_q.size() > 0) src_exp = fr_q.pop_front();
        end
        if (!src_in_pkt) begin
          src_exp[HDR_SEQ_LSB +: HDR_SEQ_W] = exp_seq;
        end
        assert (o_src_data == src_exp[63:0])
          else report_mismatch("o_src_data", src_exp[63:0], o_src_data);
        assert (o_src_last == src_exp[64])
          else report_mismatch("o_src_last", 64'(src_exp[64]), 64'(o_src_last));
        if (o_src_last) begin
          exp_seq    = exp_seq + 1'b1;
          src_in_pkt = 1'b0;
        end else begin
          src_in_pkt = 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Sink side stimulus
  //////////////////////////////////////////////////

  task automatic set_sink_readies(input int mode, input bit first);
    case (mode)
      MODE_RAW: begin
        i_samp_ready  = 1'b0;
        i_cvita_ready = rand_bit();
      end
      MODE_SAMPLE: begin
        i_cvita_ready = 1'b0;
        i_samp_ready  = rand_bit();
      end
      default: begin
        // Both consumers ready when the header shows up
        i_cvita_ready = first ? 1'b1 : rand_bit();
        i_samp_ready  = first ? 1'b1 : rand_bit();
      end
    endcase
  endtask

  task automatic send_sink_packet(input int mode, input int n_payload);
    logic [63:0] w;
    logic        moved;
    for (int i = 0; i <= n_payload; i++) begin
      w = rand_bits(64);
      if (mode != MODE_SAMPLE) cv_q.push_back({i == n_payload, w});
      if (mode != MODE_RAW && i > 0) sp_q.push_back({i == n_payload, w});
      i_sink_data  = w;
      i_sink_last  = (i == n_payload);
      i_sink_valid = 1'b1;
      set_sink_readies(mode, i == 0);
      do begin
        @(posedge ce_clk);
        moved = o_sink_ready;
        @(negedge ce_clk);
        if (!moved) set_sink_readies(mode, 1'b0);
      end while (!moved);
    end
    i_sink_valid = 1'b0;
    i_sink_last  = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Source side stimulus
  //////////////////////////////////////////////////

  // Splits the burst into framed packets of at most MAX_WORDS words
  task automatic queue_sample_burst(input int n);
    int                 m;
    int                 pos;
    logic [63:0]        w;
    logic [CVITA_W-1:0] hdr;
    m = 0;
    for (int i = 0; i < n; i++) begin
      pos = i % MAX_WORDS;
      if (pos == 0) begin
        m   = (n - i < MAX_WORDS) ? (n - i) : MAX_WORDS;
        hdr = '0;
        hdr[HDR_TYPE_MSB -: 2]        = PKT_DATA;
        hdr[HDR_LEN_LSB +: HDR_LEN_W] = 16'(8 * (m + 1));
        hdr[HDR_SRC_LSB +: HDR_SID_W] = SRC_SID;
        hdr[HDR_DST_LSB +: HDR_SID_W] = DST_SID;
        fr_q.push_back({1'b0, hdr});
      end
      w = rand_bits(64);
      fr_q.push_back({pos == m - 1, w});
      samp_stim.push_back({i == n - 1, w});
    end
  endtask

  task automatic queue_raw_packet(input int n_payload);
    logic [63:0] w;
    w = rand_bits(64);
    w[HDR_SRC_LSB +: HDR_SID_W] = RAW_SID;
    w[HDR_LEN_LSB +: HDR_LEN_W] = 16'(8 * (n_payload + 1));
    raw_q.push_back({1'b0, w});
    raw_stim.push_back({1'b0, w});
    for (int k = 1; k <= n_payload; k++) begin
      w = rand_bits(64);
      raw_q.push_back({k == n_payload, w});
      raw_stim.push_back({k == n_payload, w});
    end
  endtask

  task automatic drive_samples();
    while (samp_stim.size() > 0) begin
      {i_samp_last, i_samp_data} = samp_stim.pop_front();
      i_samp_valid = 1'b1;
      do begin
        @(posedge ce_clk);
      end while (!o_samp_ready_in);
      @(negedge ce_clk);
    end
    i_samp_valid = 1'b0;
    i_samp_last  = 1'b0;
  endtask

  task automatic drive_raw();
    while (raw_stim.size() > 0) begin
      {i_cvita_in_last, i_cvita_in_data} = raw_stim.pop_front();
      i_cvita_in_valid = 1'b1;
      do begin
        @(posedge ce_clk);
      end while (!o_cvita_in_ready);
      @(negedge ce_clk);
    end
    i_cvita_in_valid = 1'b0;
    i_cvita_in_last  = 1'b0;
  endtask

  // Source ready is high three cycles in four on average
  task automatic drive_src_ready();
    while (samp_stim.size() + raw_stim.size() + raw_q.size() + fr_q.size() > 0) begin
      @(negedge ce_clk);
      i_src_ready = rand_bit() | rand_bit();
    end
    i_src_ready = 1'b1;
  endtask

  task automatic wait_drained();
    while (cv_q.size() + sp_q.size() + raw_q.size() + fr_q.size() > 0) begin
      @(negedge ce_clk);
    end
  endtask

  task automatic run_source_round();
    int n;
    // Lengths 1 to MAX_WORDS first, then bursts that must be split
    for (int b = 0; b < N_SAMP; b++) begin
      if (b < MAX_WORDS) n = b + 1;
      else n = MAX_WORDS + 1 + int'(rand_bits(4));
      queue_sample_burst(n);
    end
    for (int p = 0; p < N_RAW; p++) begin
      queue_raw_packet(1 + int'(rand_bits(3)));
    end
    fork
      drive_samples();
      drive_raw();
      drive_src_ready();
    join
    wait_drained();
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    i_rst            = 1'b1;
    i_clear          = 1'b0;
    i_src_sid        = SRC_SID;
    i_dst_sid        = DST_SID;
    i_sink_data      = '0;
    i_sink_last      = 1'b0;
    i_sink_valid     = 1'b0;
    i_cvita_ready    = 1'b0;
    i_samp_ready     = 1'b0;
    i_samp_data      = '0;
    i_samp_last      = 1'b0;
    i_samp_valid     = 1'b0;
    i_cvita_in_data  = '0;
    i_cvita_in_last  = 1'b0;
    i_cvita_in_valid = 1'b0;
    i_src_ready      = 1'b0;
    repeat (5) @(posedge ce_clk);
    @(negedge ce_clk);
    i_rst = 1'b0;

    for (int mode = MODE_RAW; mode <= MODE_BOTH; mode++) begin
      for (int p = 0; p < N_SINK; p++) begin
        send_sink_packet(mode, 1 + int'(rand_bits(3)));
      end
    end
    i_cvita_ready = 1'b0;
    i_samp_ready  = 1'b0;
    wait_drained();

    run_source_round();
    // Sequence numbers restart after a clear between packets
    i_clear = 1'b1;
    @(negedge ce_clk);
    i_clear = 1'b0;
    run_source_round();

    // Every output is idle once all expected words have arrived
    if (o_cvita_valid || o_samp_valid || o_src_valid) begin
      stop_on_failure("A DUT output was still valid after every expected word had arrived");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

//--- design/cvita_port_bridge.sv
//////////////////////////////////////////////////
// CVITA port bridge
// One block port exposed as raw-packet and sample
// streams on both the sink and the source side
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cvita_port_bridge
  import cvita_pkg::*;
#(
  parameter int MTU_LOG2       = 5,
  parameter int REWRITE_SEQNUM = 1
) (
  input  logic                 ce_clk,
  input  logic                 i_rst,
  input  logic                 i_clear,
  input  logic [HDR_SID_W-1:0] i_src_sid,
  input  logic [HDR_SID_W-1:0] i_dst_sid,
  // Sink in
  input  logic [CVITA_W-1:0]   i_sink_data,
  input  logic                 i_sink_last,
  input  logic                 i_sink_valid,
  output logic                 o_sink_ready,
  // Raw-packet out
  output logic [CVITA_W-1:0]   o_cvita_data,
  output logic                 o_cvita_last,
  output logic                 o_cvita_valid,
  input  logic                 i_cvita_ready,
  // Sample out
  output logic [CVITA_W-1:0]   o_samp_data,
  output logic                 o_samp_last,
  output logic                 o_samp_valid,
  input  logic                 i_samp_ready,
  // Sample in
  input  logic [CVITA_W-1:0]   i_samp_data,
  input  logic                 i_samp_last,
  input  logic                 i_samp_valid,
  output logic                 o_samp_ready_in,
  // Raw-packet in
  input  logic [CVITA_W-1:0]   i_cvita_in_data,
  input  logic                 i_cvita_in_last,
  input  logic                 i_cvita_in_valid,
  output logic                 o_cvita_in_ready,
  // Source out
  output logic [CVITA_W-1:0]   o_src_data,
  output logic                 o_src_last,
  output logic                 o_src_valid,
  input  logic                 i_src_ready
);

  logic [CVITA_W-1:0] fr_data;
  logic               fr_last;
  logic               fr_valid;
  logic               fr_ready;
  logic [CVITA_W-1:0] arb_data;
  logic               arb_last;
  logic               arb_valid;
  logic               arb_ready;

  //////////////////////////////////////////////////
  // Sink side
  //////////////////////////////////////////////////

  sink_demux sink_demux_i (
    .ce_clk        (ce_clk),
    .i_rst         (i_rst),
    .i_clear       (i_clear),
    .i_data        (i_sink_data),
    .i_last        (i_sink_last),
    .i_valid       (i_sink_valid),
    .o_ready       (o_sink_ready),
    .o_cvita_data  (o_cvita_data),
    .o_cvita_last  (o_cvita_last),
    .o_cvita_valid (o_cvita_valid),
    .i_cvita_ready (i_cvita_ready),
    .o_samp_data   (o_samp_data),
    .o_samp_last   (o_samp_last),
    .o_samp_valid  (o_samp_valid),
    .i_samp_ready  (i_samp_ready)
  );

  //////////////////////////////////////////////////
  // Source side
  //////////////////////////////////////////////////

  sample_framer #(
    .MTU_LOG2 (MTU_LOG2)
  ) sample_framer_i (
    .ce_clk       (ce_clk),
    .i_rst        (i_rst),
    .i_clear      (i_clear),
    .i_samp_data  (i_samp_data),
    .i_samp_last  (i_samp_last),
    .i_samp_valid (i_samp_valid),
    .o_samp_ready (o_samp_ready_in),
    .i_src_sid    (i_src_sid),
    .i_dst_sid    (i_dst_sid),
    .o_data       (fr_data),
    .o_last       (fr_last),
    .o_valid      (fr_valid),
    .i_ready      (fr_ready)
  );

  source_arbiter source_arbiter_i (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_clear    (i_clear),
    .i_fr_data  (fr_data),
    .i_fr_last  (fr_last),
    .i_fr_valid (fr_valid),
    .o_fr_ready (fr_ready),
    .i_cv_data  (i_cvita_in_data),
    .i_cv_last  (i_cvita_in_last),
    .i_cv_valid (i_cvita_in_valid),
    .o_cv_ready (o_cvita_in_ready),
    .o_data     (arb_data),
    .o_last     (arb_last),
    .o_valid    (arb_valid),
    .i_ready    (arb_ready)
  );

  seqnum_rewriter #(
    .REWRITE_SEQNUM (REWRITE_SEQNUM)
  ) seqnum_rewriter_i (
    .ce_clk  (ce_clk),
    .i_rst   (i_rst),
    .i_clear (i_clear),
    .i_data  (arb_data),
    .i_last  (arb_last),
    .i_valid (arb_valid),
    .o_ready (arb_ready),
    .o_data  (o_src_data),
    .o_last  (o_src_last),
    .o_valid (o_src_valid),
    .i_ready (i_src_ready)
  );

endmodule

//--- design/seqnum_rewriter.sv
//////////////////////////////////////////////////
// Sequence number rewriter
// Overwrites the header sequence number of each
// outgoing packet with a running packet count
//////////////////////////////////////////////////

`timescale 1ns/1ps

module seqnum_rewriter
  import cvita_pkg::*;
#(
  parameter int REWRITE_SEQNUM = 1
) (
  input  logic               ce_clk,
  input  logic               i_rst,
  input  logic               i_clear,
  // Merged source stream
  input  logic [CVITA_W-1:0] i_data,
  input  logic               i_last,
  input  logic               i_valid,
  output logic               o_ready,
  // Port output
  output logic [CVITA_W-1:0] o_data,
  output logic               o_last,
  output logic               o_valid,
  input  logic               i_ready
);

  logic                 first;
  logic [HDR_SEQ_W-1:0] seq_cnt;
  logic                 xfer;

  assign xfer    = i_valid && i_ready;
  assign o_ready = i_ready;
  assign o_valid = i_valid;
  assign o_last  = i_last;

  // First word after a last is always a header
  always_ff @(posedge ce_clk) begin
    if (i_rst || i_clear) begin
      first   <= 1'b1;
      seq_cnt <= '0;
    end else if (xfer) begin
      first <= i_last;
      if (i_last) begin
        seq_cnt <= seq_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    o_data = i_data;
    if ((REWRITE_SEQNUM != 0) && first) begin
      o_data[HDR_SEQ_LSB +: HDR_SEQ_W] = seq_cnt;
    end
  end

endmodule

//--- design/source_arbiter.sv
//////////////////////////////////////////////////
// Source arbiter
// Round-robin mux of the framer and raw-packet
// streams, locked to whole packets
//////////////////////////////////////////////////

`timescale 1ns/1ps

module source_arbiter
  import cvita_pkg::*;
(
  input  logic               ce_clk,
  input  logic               i_rst,
  input  logic               i_clear,
  // Framer stream
  input  logic [CVITA_W-1:0] i_fr_data,
  input  logic               i_fr_last,
  input  logic               i_fr_valid,
  output logic               o_fr_ready,
  // User raw-packet stream
  input  logic [CVITA_W-1:0] i_cv_data,
  input  logic               i_cv_last,
  input  logic               i_cv_valid,
  output logic               o_cv_ready,
  // Merged stream
  output logic [CVITA_W-1:0] o_data,
  output logic               o_last,
  output logic               o_valid,
  input  logic               i_ready
);

  // Grant of 1 selects the raw-packet stream
  logic busy;
  logic grant;
  logic last_served;
  logic pick_cv;
  logic sel;

  // Framer wins a tie unless it was served last
  assign pick_cv = i_cv_valid && (!i_fr_valid || !last_served);
  assign sel     = busy ? grant : pick_cv;

  assign o_data  = sel ? i_cv_data  : i_fr_data;
  assign o_last  = sel ? i_cv_last  : i_fr_last;
  assign o_valid = sel ? i_cv_valid : i_fr_valid;

  assign o_fr_ready = !sel && i_ready;
  assign o_cv_ready = sel && i_ready;

  always_ff @(posedge ce_clk) begin
    if (i_rst || i_clear) begin
      busy        <= 1'b0;
      grant       <= 1'b0;
      last_served <= 1'b1;
    end else if (o_valid) begin
      if (i_ready && o_last) begin
        busy        <= 1'b0;
        last_served <= sel;
      end else begin
        // Hold the choice once a word is on offer
        busy  <= 1'b1;
        grant <= sel;
      end
    end
  end

endmodule

//--- design/sample_framer.sv
//////////////////////////////////////////////////
// Sample framer
// Buffers user sample words into one packet and sends
// it behind a generated CVITA data header
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sample_framer
  import cvita_pkg::*;
#(
  parameter int MTU_LOG2 = 5
) (
  input  logic                 ce_clk,
  input  logic                 i_rst,
  input  logic                 i_clear,
  // User sample stream
  input  logic [CVITA_W-1:0]   i_samp_data,
  input  logic                 i_samp_last,
  input  logic                 i_samp_valid,
  output logic                 o_samp_ready,
  // Stream IDs placed in the header
  input  logic [HDR_SID_W-1:0] i_src_sid,
  input  logic [HDR_SID_W-1:0] i_dst_sid,
  // Framed packet stream
  output logic [CVITA_W-1:0]   o_data,
  output logic                 o_last,
  output logic                 o_valid,
  input  logic                 i_ready
);

  localparam int DEPTH = 2 ** MTU_LOG2;
  localparam logic [MTU_LOG2:0] LAST_IDX = (MTU_LOG2 + 1)'(DEPTH - 1);

  logic [CVITA_W-1:0]   mem [DEPTH];
  logic [MTU_LOG2:0]    wr_cnt;
  logic [MTU_LOG2-1:0]  rd_ptr;
  framer_state_e        state;
  logic                 wr_en;
  logic                 rd_xfer;
  logic                 body_last;
  logic [HDR_LEN_W-1:0] hdr_len;
  logic [CVITA_W-1:0]   hdr;

  assign o_samp_ready = (state == FR_FILL);
  assign wr_en        = i_samp_valid && o_samp_ready;
  assign rd_xfer      = o_valid && i_ready;
  assign body_last    = ({1'b0, rd_ptr} == (wr_cnt - 1'b1));

  // Sample buffer write port
  always_ff @(posedge ce_clk) begin
    if (wr_en) begin
      mem[wr_cnt[MTU_LOG2-1:0]] <= i_samp_data;
    end
  end

  //////////////////////////////////////////////////
  // Header build
  //////////////////////////////////////////////////

  // Length in bytes counts the header word too
  assign hdr_len = HDR_LEN_W'(wr_cnt + 1'b1) << 3;

  always_comb begin
    hdr = '0;
    hdr[HDR_TYPE_MSB -: 2]           = PKT_DATA;
    hdr[HDR_HAS_TIME_BIT]            = 1'b0;
    hdr[HDR_EOB_BIT]                 = 1'b0;
    hdr[HDR_SEQ_LSB +: HDR_SEQ_W]    = '0;
    hdr[HDR_LEN_LSB +: HDR_LEN_W]    = hdr_len;
    hdr[HDR_SRC_LSB +: HDR_SID_W]    = i_src_sid;
    hdr[HDR_DST_LSB +: HDR_SID_W]    = i_dst_sid;
  end

  assign o_valid = (state != FR_FILL);
  assign o_data  = (state == FR_HDR) ? hdr : mem[rd_ptr];
  assign o_last  = (state == FR_BODY) && body_last;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_rst || i_clear) begin
      state  <= FR_FILL;
      wr_cnt <= '0;
      rd_ptr <= '0;
    end else begin
      case (state)
        FR_FILL: begin
          if (wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
            // Close early when the buffer fills up
            if (i_samp_last || (wr_cnt == LAST_IDX)) begin
              state <= FR_HDR;
            end
          end
        end
        FR_HDR: begin
          if (rd_xfer) begin
            rd_ptr <= '0;
            state  <= FR_BODY;
          end
        end
        FR_BODY: begin
          if (rd_xfer) begin
            rd_ptr <= rd_ptr + 1'b1;
            if (body_last) begin
              wr_cnt <= '0;
              state  <= FR_FILL;
            end
          end
        end
        default: state <= FR_FILL;
      endcase
    end
  end

endmodule

//--- design/sink_demux.sv
//////////////////////////////////////////////////
// Sink demux
// Routes each incoming CVITA packet to the raw-packet
// consumer, the sample consumer or both, using the
// consumer readies seen when the packet appears
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sink_demux
  import cvita_pkg::*;
(
  input  logic               ce_clk,
  input  logic               i_rst,
  input  logic               i_clear,
  // Incoming packet stream
  input  logic [CVITA_W-1:0] i_data,
  input  logic               i_last,
  input  logic               i_valid,
  output logic               o_ready,
  // Raw-packet consumer
  output logic [CVITA_W-1:0] o_cvita_data,
  output logic               o_cvita_last,
  output logic               o_cvita_valid,
  input  logic               i_cvita_ready,
  // Sample consumer, payload only
  output logic [CVITA_W-1:0] o_samp_data,
  output logic               o_samp_last,
  output logic               o_samp_valid,
  input  logic               i_samp_ready
);

  route_e route;
  logic   hdr_phase;
  logic   routed;
  logic   to_cv;
  logic   to_sp;
  logic   sink_xfer;

  //////////////////////////////////////////////////
  // Route selection
  //////////////////////////////////////////////////

  assign routed = (route != ROUTE_NONE);

  // Header only ever goes to the raw-packet side
  assign to_cv = (route == ROUTE_CVITA) || (route == ROUTE_BOTH);
  assign to_sp = ((route == ROUTE_SAMPLE) || (route == ROUTE_BOTH)) && !hdr_phase;

  always_ff @(posedge ce_clk) begin
    if (i_rst || i_clear) begin
      route     <= ROUTE_NONE;
      hdr_phase <= 1'b1;
    end else if (!routed) begin
      // Latch the destination from whoever is ready right now
      if (i_valid && (i_cvita_ready || i_samp_ready)) begin
        route     <= route_e'({i_cvita_ready, i_samp_ready});
        hdr_phase <= 1'b1;
      end
    end else if (sink_xfer) begin
      hdr_phase <= 1'b0;
      if (i_last) begin
        route     <= ROUTE_NONE;
        hdr_phase <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////

  // When both are selected each side waits for the other, so a word
  // moves to both consumers in the same cycle
  assign o_cvita_valid = i_valid && to_cv && (!to_sp || i_samp_ready);
  assign o_samp_valid  = i_valid && to_sp && (!to_cv || i_cvita_ready);

  // A header on a sample-only route is accepted and dropped
  assign o_ready = routed && (!to_cv || i_cvita_ready) && (!to_sp || i_samp_ready);

  assign sink_xfer = i_valid && o_ready;

  assign o_cvita_data = i_data;
  assign o_cvita_last = i_last;
  assign o_samp_data  = i_data;
  assign o_samp_last  = i_last;

endmodule

//--- design/cvita_pkg.sv
//////////////////////////////////////////////////
// CVITA definitions
// Header field positions and the enums shared by
// the port bridge blocks
//////////////////////////////////////////////////

package cvita_pkg;

  // Packet word width
  localparam int CVITA_W = 64;

  // Header field positions
  localparam int HDR_TYPE_MSB     = 63;
  localparam int HDR_HAS_TIME_BIT = 61;
  localparam int HDR_EOB_BIT      = 60;
  localparam int HDR_SEQ_LSB      = 48;
  localparam int HDR_SEQ_W        = 12;
  localparam int HDR_LEN_LSB      = 32;
  localparam int HDR_LEN_W        = 16;
  localparam int HDR_SRC_LSB      = 16;
  localparam int HDR_DST_LSB      = 0;
  localparam int HDR_SID_W        = 16;

  typedef enum logic [1:0] {
    PKT_DATA = 2'd0,
    PKT_FLOW = 2'd1,
    PKT_CMD  = 2'd2,
    PKT_RESP = 2'd3
  } pkt_type_e;

  // Bit 1 selects the raw-packet output, bit 0 the sample output
  typedef enum logic [1:0] {
    ROUTE_NONE   = 2'd0,
    ROUTE_SAMPLE = 2'd1,
    ROUTE_CVITA  = 2'd2,
    ROUTE_BOTH   = 2'd3
  } route_e;

  typedef enum logic [1:0] {
    FR_FILL,
    FR_HDR,
    FR_BODY
  } framer_state_e;

endpackage
